// ==== hw/fdc_pkg.sv ====
package fdc_pkg;

	// host register map, command shares the status address
	localparam logic [2:0] a_status  = 3'b000;
	localparam logic [2:0] a_command = 3'b000;
	localparam logic [2:0] a_track   = 3'b001;
	localparam logic [2:0] a_sector  = 3'b010;
	localparam logic [2:0] a_data    = 3'b011;
	localparam logic [2:0] a_ctl2    = 3'b111;   // bit 2 selects the side

	// status bits common to both layouts
	localparam int sbit_busy     = 0;
	localparam int sbit_crcerr   = 3;
	localparam int sbit_seekerr  = 4;
	localparam int sbit_readonly = 6;
	localparam int sbit_notready = 7;

	// type I layout (mode 1)
	localparam int sbit_index    = 1;
	localparam int sbit_track0   = 2;
	localparam int sbit_headload = 5;

	// type II layout (mode 2)
	localparam int sbit_drq      = 1;
	localparam int sbit_lostdata = 2;
	localparam int sbit_wrfault  = 5;

	// disk geometry
	localparam int sector_size       = 1024;
	localparam int readaddr_size     = 6;    // track, side, sector, size, two check bytes
	localparam int sectors_per_track = 5;    // numbered 1 to 5
	localparam int track_count       = 80;

	// timing in clock cycles
	localparam int watchdog_time = 255;   // max unserviced drq time
	localparam int fetch_delay   = 15;    // pause before drq for the next byte

	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write,
		op_readaddr
	} disk_op_e;

	typedef enum logic [2:0] {
		st_ready,
		st_wait_read,
		st_wait_ack,
		st_reset,
		st_fetch,
		st_fetch_wait,
		st_next_addr,
		st_wait_write
	} fdc_state_e;

	// request from the controller toward the drive
	typedef struct packed {
		disk_op_e   op;
		logic       side;
		logic [7:0] track;    // head position, not the track register
		logic [7:0] sector;
	} disk_req_t;

	typedef struct packed {
		logic done;
		logic ok;
	} disk_rsp_t;

endpackage

// ==== hw/drq_watchdog.sv ====
`timescale 1ns/1ps

module drq_watchdog (
	input  logic clk,
	input  logic cock,
	input  logic kick,
	output logic expired
);
	import fdc_pkg::*;

	logic [15:0] count;

	// reloads on every serviced byte, sticks at zero once run out
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			count <= 16'(watchdog_time);
		end else if (kick) begin
			count <= 16'(watchdog_time);
		end else if (count != 16'd0) begin
			count <= count - 16'd1;
		end
	end

	assign expired = (count == 16'd0);

endmodule

// ==== hw/sector_buffer.sv ====
`timescale 1ns/1ps

module sector_buffer (
	input  logic       clk,
	input  logic       we,
	input  logic [9:0] waddr,
	input  logic [7:0] wdata,
	input  logic [9:0] raddr,
	output logic [7:0] rdata
);
	import fdc_pkg::*;

	logic [7:0] mem [sector_size];   // one sector

	// drive side fills
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// host side reads, one cycle latency
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== hw/disk_server.sv ====
`timescale 1ns/1ps

module disk_server (
	input  logic               clk,
	input  logic               cock,
	input  fdc_pkg::disk_req_t req,
	output fdc_pkg::disk_rsp_t rsp,
	output logic               buf_we,
	output logic [9:0]         buf_waddr,
	output logic [7:0]         buf_wdata
);
	import fdc_pkg::*;

	typedef enum logic [2:0] {
		srv_idle,
		srv_seek,
		srv_fill,
		srv_answer,
		srv_release
	} srv_state_e;

	srv_state_e state;
	logic [7:0] head;    // drive's own head position
	logic [9:0] idx;     // byte being written
	logic       ok_q;

	logic       track_ok;
	logic       sector_ok;
	logic       last;
	logic [7:0] side_byte;
	logic [7:0] check;

	assign track_ok  = (req.track < 8'(track_count));
	assign sector_ok = (req.sector >= 8'd1) && (req.sector <= 8'(sectors_per_track));
	assign side_byte = {7'd0, req.side};
	assign check     = req.track ^ side_byte ^ req.sector ^ 8'd3;
	assign last      = (req.op == op_readaddr) ? (idx == 10'(readaddr_size - 1))
	                                           : (idx == 10'(sector_size - 1));

	// generated sector content or the address field
	always_comb begin
		if (req.op == op_readaddr) begin
			case (idx[2:0])
				3'd0:    buf_wdata = req.track;
				3'd1:    buf_wdata = side_byte;
				3'd2:    buf_wdata = req.sector;
				3'd3:    buf_wdata = 8'd3;   // size code for 1024 bytes
				default: buf_wdata = check;
			endcase
		end else begin
			buf_wdata = idx[7:0] ^ req.track ^ {req.sector[3:0], 4'd0} ^ {req.side, 7'd0};
		end
	end

	assign buf_we    = (state == srv_fill);
	assign buf_waddr = idx;

	// an idle nop is acknowledged at once
	always_comb begin
		rsp.done = (state == srv_answer) || (state == srv_idle && req.op == op_none);
		rsp.ok   = (state == srv_answer) ? ok_q : 1'b1;
	end

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state <= srv_idle;
			head  <= '0;
			idx   <= '0;
			ok_q  <= 1'b0;
		end else begin
			case (state)
				srv_idle: begin
					if (req.op != op_none)
						state <= srv_seek;
				end
				srv_seek: begin
					idx <= '0;
					if (head < req.track) begin
						head <= head + 8'd1;
					end else if (head > req.track) begin
						head <= head - 8'd1;
					end else begin
						case (req.op)
							op_read: begin
								ok_q  <= track_ok && sector_ok;
								state <= (track_ok && sector_ok) ? srv_fill : srv_answer;
							end
							op_readaddr: begin
								ok_q  <= track_ok;
								state <= track_ok ? srv_fill : srv_answer;
							end
							default: begin   // writes are always refused
								ok_q  <= 1'b0;
								state <= srv_answer;
							end
						endcase
					end
				end
				srv_fill: begin
					idx <= idx + 10'd1;
					if (last)
						state <= srv_answer;
				end
				srv_answer: state <= srv_release;
				srv_release: begin
					if (req.op == op_none)
						state <= srv_idle;
				end
				default: state <= srv_idle;
			endcase
		end
	end

endmodule

// ==== hw/fdc_core.sv ====
`timescale 1ns/1ps

module fdc_core (
	input  logic               clk,
	input  logic               cock,
	input  logic               rd,
	input  logic               wr,
	input  logic [2:0]         addr,
	input  logic [7:0]         wdata,
	output logic [7:0]         rdata,
	output logic               irq,
	output logic               drq,
	output fdc_pkg::disk_req_t req,
	input  fdc_pkg::disk_rsp_t rsp,
	output logic [9:0]         buf_raddr,
	input  logic [7:0]         buf_rdata,
	output logic               kick,
	input  logic               expired
);
	import fdc_pkg::*;

	fdc_state_e  state;
	logic [7:0]  track_reg;
	logic [7:0]  sector_reg;
	logic [7:0]  data_reg;
	logic [7:0]  disk_track;    // real head position
	logic        side;
	logic        step_dir;      // 0 steps in, 1 steps out
	logic        multi;
	logic        cmd_mode;      // status layout of the last command
	logic        busy;
	logic        headload;
	logic        index_seen;
	logic        seekerr;
	logic        lostdata;
	logic [10:0] remaining;     // bytes still to hand out
	logic [3:0]  fetch_timer;
	logic [7:0]  status;

	logic       data_rd;
	logic       byte_take;
	logic       last_byte;
	logic       arrival;
	logic       dir;
	logic [7:0] next_track;

	assign data_rd   = rd && (addr == a_data);
	// byte leaves the buffer, read by the host or lost
	assign byte_take = (state == st_ready) && drq && (data_rd || expired);
	assign last_byte = (remaining == 11'd1);
	assign arrival   = (state == st_wait_read) && rsp.done && rsp.ok;
	assign kick      = byte_take || arrival;

	assign dir        = wdata[6] ? wdata[5] : step_dir;   // plain STEP reuses last direction
	assign next_track = dir ? disk_track - 8'd1 : disk_track + 8'd1;

	always_comb begin
		status = '0;
		status[sbit_busy]     = busy;
		status[sbit_crcerr]   = 1'b0;   // emulated media has no crc faults
		status[sbit_seekerr]  = seekerr;
		status[sbit_readonly] = 1'b0;
		status[sbit_notready] = 1'b0;
		if (cmd_mode) begin
			status[sbit_drq]      = drq;
			status[sbit_lostdata] = lostdata;
			status[sbit_wrfault]  = 1'b0;
		end else begin
			status[sbit_index]    = index_seen;
			status[sbit_track0]   = (disk_track == 8'd0);
			status[sbit_headload] = headload;
		end
	end

	// host read data and the data register
	always_ff @(posedge clk) begin
		if (rd) begin
			case (addr)
				a_status: rdata <= status;
				a_track:  rdata <= track_reg;
				a_sector: rdata <= sector_reg;
				a_data:   rdata <= byte_take ? buf_rdata : data_reg;
				a_ctl2:   rdata <= {5'b11111, side, 2'b00};
				default:  rdata <= 8'hff;
			endcase
		end
		if (byte_take && data_rd)
			data_reg <= buf_rdata;
		else if (wr && addr == a_data)
			data_reg <= wdata;   // seek target
	end

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state       <= st_ready;
			track_reg   <= '0;
			sector_reg  <= '0;
			disk_track  <= 8'hff;   // unknown until restore
			side        <= 1'b0;
			step_dir    <= 1'b0;
			multi       <= 1'b0;
			cmd_mode    <= 1'b0;
			busy        <= 1'b0;
			drq         <= 1'b0;
			irq         <= 1'b0;
			headload    <= 1'b0;
			index_seen  <= 1'b0;
			seekerr     <= 1'b0;
			lostdata    <= 1'b0;
			remaining   <= '0;
			fetch_timer <= '0;
			buf_raddr   <= '0;
			req.op      <= op_none;
			req.side    <= 1'b0;
			req.track   <= '0;
			req.sector  <= '0;
		end else begin
			if (rd && addr == a_status)
				irq <= 1'b0;   // status read acknowledges

			case (state)
				st_ready: begin
					if (byte_take) begin
						drq       <= 1'b0;
						remaining <= remaining - 11'd1;
						if (!data_rd)
							lostdata <= 1'b1;
						if (!last_byte) begin
							state <= st_next_addr;
						end else if (multi && sector_reg < 8'(sectors_per_track)) begin
							sector_reg <= sector_reg + 8'd1;
							req.sector <= sector_reg + 8'd1;
							req.op     <= op_read;
							remaining  <= 11'(sector_size);
							state      <= st_wait_read;
						end else begin
							busy  <= 1'b0;
							irq   <= 1'b1;
							multi <= 1'b0;
						end
					end
				end
				st_next_addr: begin
					buf_raddr <= buf_raddr + 10'd1;   // wraps to 0 on a fresh sector
					state     <= st_fetch;
				end
				st_fetch: begin
					fetch_timer <= 4'(fetch_delay);
					state       <= st_fetch_wait;
				end
				st_fetch_wait: begin
					if (fetch_timer != 4'd0) begin
						fetch_timer <= fetch_timer - 4'd1;
					end else begin
						drq   <= 1'b1;
						state <= st_ready;
					end
				end
				st_wait_read: begin
					if (rsp.done) begin
						req.op <= op_none;
						if (rsp.ok) begin
							buf_raddr <= 10'h3ff;
							state     <= st_next_addr;
						end else begin
							seekerr <= 1'b1;   // sector not found
							busy    <= 1'b0;
							irq     <= 1'b1;
							multi   <= 1'b0;
							state   <= st_ready;
						end
					end
				end
				st_wait_write: begin
					if (rsp.done) begin
						req.op  <= op_none;
						seekerr <= !rsp.ok;
						busy    <= 1'b0;
						irq     <= 1'b1;
						state   <= st_ready;
					end
				end
				st_wait_ack: begin
					if (rsp.done) begin
						busy  <= 1'b0;
						irq   <= 1'b1;
						state <= st_ready;
					end
				end
				st_reset: begin
					busy   <= 1'b0;
					drq    <= 1'b0;
					irq    <= 1'b0;
					multi  <= 1'b0;
					req.op <= op_none;
					state  <= st_ready;
				end
			endcase

			if (wr) begin
				case (addr)
					a_track: begin
						if (!busy)
							track_reg <= wdata;
					end
					a_sector: begin
						if (!busy)
							sector_reg <= wdata;
					end
					a_ctl2: side <= wdata[2];
					a_command: begin
						if (wdata[7:4] == 4'hd) begin
							state <= st_reset;   // force interrupt
						end else if (!busy && wdata[7:4] <= 4'hc) begin
							cmd_mode <= wdata[7];
							irq      <= 1'b0;
							busy     <= 1'b1;
							seekerr  <= 1'b0;
							lostdata <= 1'b0;
							if (!wdata[7]) begin
								headload   <= wdata[3];
								index_seen <= 1'b1;
								state      <= st_wait_ack;
							end else begin
								req.side   <= side;
								req.track  <= disk_track;
								req.sector <= sector_reg;
								drq        <= 1'b0;
							end
							case (wdata[7:4])
								4'h0: begin   // restore
									track_reg  <= '0;
									disk_track <= '0;
								end
								4'h1: disk_track <= data_reg;   // seek
								4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
									if (wdata[6])
										step_dir <= wdata[5];
									disk_track <= next_track;
									if (wdata[4])
										track_reg <= next_track;
								end
								4'h8, 4'h9: begin
									req.op    <= op_read;
									remaining <= 11'(sector_size);
									multi     <= wdata[4];
									state     <= st_wait_read;
								end
								4'ha, 4'hb: begin
									req.op <= op_write;
									multi  <= 1'b0;
									state  <= st_wait_write;
								end
								default: begin   // read address
									req.op    <= op_readaddr;
									remaining <= 11'(readaddr_size);
									multi     <= 1'b0;
									state     <= st_wait_read;
								end
							endcase
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hw/fdc_top.sv ====
`timescale 1ns/1ps

module fdc_top (
	input  logic       clk,
	input  logic       cock,
	input  logic       rd,
	input  logic       wr,
	input  logic [2:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       irq,
	output logic       drq
);
	import fdc_pkg::*;

	disk_req_t  req;
	disk_rsp_t  rsp;
	logic [9:0] buf_raddr;
	logic [7:0] buf_rdata;
	logic       buf_we;
	logic [9:0] buf_waddr;
	logic [7:0] buf_wdata;
	logic       kick;
	logic       expired;

	fdc_core u_core (
		.clk       (clk),
		.cock      (cock),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.irq       (irq),
		.drq       (drq),
		.req       (req),
		.rsp       (rsp),
		.buf_raddr (buf_raddr),
		.buf_rdata (buf_rdata),
		.kick      (kick),
		.expired   (expired)
	);

	drq_watchdog u_dog (
		.clk     (clk),
		.cock    (cock),
		.kick    (kick),
		.expired (expired)
	);

	sector_buffer u_buf (
		.clk   (clk),
		.we    (buf_we),
		.waddr (buf_waddr),
		.wdata (buf_wdata),
		.raddr (buf_raddr),
		.rdata (buf_rdata)
	);

	// emulated drive
	disk_server u_srv (
		.clk       (clk),
		.cock      (cock),
		.req       (req),
		.rsp       (rsp),
		.buf_we    (buf_we),
		.buf_waddr (buf_waddr),
		.buf_wdata (buf_wdata)
	);

endmodule

// ==== test/fdc_assertions.sv ====
`timescale 1ns/1ps

module fdc_core_assertions (
	input logic               clk,
	input logic               cock,
	input logic               busy,
	input logic               drq,
	input logic               irq,
	input fdc_pkg::disk_req_t req,
	input fdc_pkg::disk_rsp_t rsp
);
	import fdc_pkg::*;

	int failures = 0;   // count of failed assertions

	// data requests only inside a running command
	drq_needs_busy: assert property (@(posedge clk) disable iff (cock)
		!(drq && !busy))
		else begin
			failures++;
			$error("drq high while busy is low");
		end

	// request released right after the drive answers
	req_released: assert property (@(posedge clk) disable iff (cock)
		(rsp.done && req.op != op_none) |=> (req.op == op_none))
		else begin
			failures++;
			$error("req.op still active the cycle after rsp.done");
		end

	irq_not_busy: assert property (@(posedge clk) disable iff (cock)
		!(irq && busy))
		else begin
			failures++;
			$error("irq and busy high together");
		end

endmodule

bind fdc_core fdc_core_assertions u_assert (
	.clk  (clk),
	.cock (cock),
	.busy (busy),
	.drq  (drq),
	.irq  (irq),
	.req  (req),
	.rsp  (rsp)
);

// ==== test/fdc_tb.sv ====
`timescale 1ns/1ps

module fdc_tb;
	import fdc_pkg::*;

	localparam int drq_limit  = 4000;   // covers head seek plus a full sector fill
	localparam int irq_limit  = 4000;
	localparam int busy_limit = 100;

	typedef enum logic [2:0] {
		act_write,
		act_read,
		act_stream,
		act_addr,
		act_irq,
		act_busy,
		act_idle
	} act_e;

	// stream entries carry the byte count in data
	typedef struct packed {
		act_e        act;
		logic [2:0]  addr;
		logic [15:0] data;
		logic [7:0]  exp;
		logic [7:0]  mask;
		logic [7:0]  trk;
		logic        side;
		logic [7:0]  sec;
	} step_t;

	logic       clk;
	logic       cock;
	logic       rd;
	logic       wr;
	logic [2:0] addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       irq;
	logic       drq;

	step_t       steps[$];
	int          errors;
	int          timeouts;
	int unsigned gap;

	fdc_top UUT (
		.clk   (clk),
		.cock  (cock),
		.rd    (rd),
		.wr    (wr),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.irq   (irq),
		.drq   (drq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// expected data byte of a generated sector
	function automatic logic [7:0] sector_byte(int i, logic [7:0] t, logic h, logic [7:0] s);
		logic [7:0] b;
		b = 8'(i) ^ t ^ 8'(int'(s) * 16);
		if (h)
			b = b ^ 8'h80;
		return b;
	endfunction

	// address field of track, side, sector and size code plus two check bytes
	function automatic logic [7:0] addr_byte(int i, logic [7:0] t, logic h, logic [7:0] s);
		logic [7:0] field [4];
		field[0] = t;
		field[1] = {7'd0, h};
		field[2] = s;
		field[3] = 8'd3;
		if (i < 4)
			return field[i];
		return field[0] ^ field[1] ^ field[2] ^ field[3];
	endfunction

	function automatic void write_step(logic [2:0] a, logic [7:0] d);
		step_t s;
		s = '0;
		s.act = act_write;
		s.addr = a;
		s.data = {8'd0, d};
		steps.push_back(s);
	endfunction

	function automatic void read_step(logic [2:0] a, logic [7:0] e, logic [7:0] m);
		step_t s;
		s = '0;
		s.act = act_read;
		s.addr = a;
		s.exp = e;
		s.mask = m;
		steps.push_back(s);
	endfunction

	function automatic void stream_step(act_e act, int count, logic [7:0] t, logic h,
			logic [7:0] sec);
		step_t s;
		s = '0;
		s.act = act;
		s.data = 16'(count);
		s.trk = t;
		s.side = h;
		s.sec = sec;
		steps.push_back(s);
	endfunction

	function automatic void wait_step(act_e act, int cycles);
		step_t s;
		s = '0;
		s.act = act;
		s.data = 16'(cycles);
		steps.push_back(s);
	endfunction

	task automatic build_table();
		write_step(a_command, 8'h08);             // restore
		wait_step(act_irq, 0);
		read_step(a_status, 8'h24, 8'h25);        // track0, head loaded, idle
		read_step(a_track, 8'h00, 8'hff);
		repeat (3) begin
			write_step(a_command, 8'h58);         // step in, update
			wait_step(act_irq, 0);
		end
		read_step(a_track, 8'h03, 8'hff);
		write_step(a_command, 8'h78);             // step out, update
		wait_step(act_irq, 0);
		read_step(a_track, 8'h02, 8'hff);
		write_step(a_data, 8'd10);
		write_step(a_command, 8'h18);             // seek to 10
		wait_step(act_irq, 0);
		read_step(a_track, 8'h02, 8'hff);
		read_step(a_status, 8'h20, 8'h25);
		// single sector on side 1
		write_step(a_ctl2, 8'h04);
		read_step(a_ctl2, 8'h04, 8'h04);
		write_step(a_sector, 8'd2);
		write_step(a_command, 8'h80);
		stream_step(act_stream, sector_size, 8'd10, 1'b1, 8'd2);
		wait_step(act_irq, 0);
		read_step(a_status, 8'h00, 8'h17);
		// multi sector from 4
		write_step(a_sector, 8'd4);
		write_step(a_command, 8'h90);
		stream_step(act_stream, sector_size, 8'd10, 1'b1, 8'd4);
		stream_step(act_stream, sector_size, 8'd10, 1'b1, 8'd5);
		wait_step(act_irq, 0);
		read_step(a_sector, 8'd5, 8'hff);
		read_step(a_status, 8'h00, 8'h03);
		write_step(a_command, 8'hc0);             // read address
		stream_step(act_addr, readaddr_size, 8'd10, 1'b1, 8'd5);
		wait_step(act_irq, 0);
		read_step(a_status, 8'h00, 8'h13);
		// missing sector, then refused write
		write_step(a_sector, 8'd9);
		write_step(a_command, 8'h80);
		wait_step(act_irq, 0);
		read_step(a_status, 8'h10, 8'h11);
		write_step(a_sector, 8'd1);
		write_step(a_command, 8'ha0);
		wait_step(act_irq, 0);
		read_step(a_status, 8'h10, 8'h11);
		// host stalls mid-sector
		write_step(a_command, 8'h80);
		stream_step(act_stream, 100, 8'd10, 1'b1, 8'd1);
		wait_step(act_idle, 400);
		read_step(a_status, 8'h05, 8'h05);        // busy with lost data
		write_step(a_command, 8'hd0);             // force interrupt
		wait_step(act_busy, 0);
		read_step(a_status, 8'h00, 8'h03);
	endtask

	// bus tasks start and end just after a falling edge
	task automatic bus_write(logic [2:0] a, logic [7:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic bus_read(logic [2:0] a, output logic [7:0] d);
		addr = a;
		rd = 1'b1;
		@(negedge clk);
		rd = 1'b0;
		d = rdata;
	endtask

	task automatic wait_level(input bit use_irq, input int limit, output bit ok);
		int n;
		n = 0;
		while (!(use_irq ? irq : drq) && n < limit) begin
			@(negedge clk);
			n++;
		end
		ok = use_irq ? irq : drq;
	endtask

	// polls the status register until the busy bit drops
	task automatic wait_not_busy(input int limit, output bit ok);
		logic [7:0] st;
		int         n;
		n = 0;
		bus_read(a_status, st);
		while (st[sbit_busy] && n < limit) begin
			bus_read(a_status, st);
			n++;
		end
		ok = !st[sbit_busy];
	endtask

	task automatic read_stream(step_t s);
		logic [7:0] got;
		logic [7:0] exp;
		bit         ok;
		for (int i = 0; i < int'(s.data); i++) begin
			wait_level(1'b0, drq_limit, ok);
			if (!ok) begin
				$display("Timed out waiting for drq before byte %0d of sector %0d", i, s.sec);
				timeouts++;
				return;
			end
			bus_read(a_data, got);
			if (s.act == act_addr)
				exp = addr_byte(i, s.trk, s.side, s.sec);
			else
				exp = sector_byte(i, s.trk, s.side, s.sec);
			if (got !== exp) begin
				errors++;
				$display("[ERROR] %0t: sector %0d byte %0d read %02h, expected %02h",
					$time, s.sec, i, got, exp);
			end
		end
	endtask

	initial begin
		step_t      s;
		logic [7:0] got;
		bit         ok;
		int         asserts;
		cock = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		errors = 0;
		timeouts = 0;
		gap = $urandom(32'he6e4_2642);   // seeds the generator
		build_table();
		repeat (4) @(negedge clk);
		cock = 1'b0;
		@(negedge clk);

		for (int k = 0; k < steps.size() && timeouts == 0; k++) begin
			s = steps[k];
			case (s.act)
				act_write: bus_write(s.addr, s.data[7:0]);
				act_read: begin
					bus_read(s.addr, got);
					if ((got & s.mask) !== (s.exp & s.mask)) begin
						errors++;
						$display("[ERROR] %0t: step %0d register %0d read %02h, expected %02h/%02h",
							$time, k, s.addr, got, s.exp, s.mask);
					end
				end
				act_stream, act_addr: read_stream(s);
				act_irq: begin
					wait_level(1'b1, irq_limit, ok);
					if (!ok) begin
						$display("Timed out waiting for irq at step %0d", k);
						timeouts++;
					end
				end
				act_busy: begin
					wait_not_busy(busy_limit, ok);
					if (!ok) begin
						$display("Timed out waiting for busy to clear at step %0d", k);
						timeouts++;
					end
				end
				act_idle: repeat (s.data) @(negedge clk);
				default: ;
			endcase
			gap = $urandom % 4;   // random spacing between entries
			repeat (gap) @(negedge clk);
		end

		asserts = UUT.u_core.u_assert.failures;
		$display("errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, asserts);
		if (errors == 0 && timeouts == 0 && asserts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/fdc_pkg.sv
hw/drq_watchdog.sv
hw/sector_buffer.sv
hw/disk_server.sv
hw/fdc_core.sv
hw/fdc_top.sv
test/fdc_assertions.sv
test/fdc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := fdc_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help  - list the targets"
	@echo "  test  - build with Verilator, run the testbench, check the log"
	@echo "  clean - remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "test FAILED, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
